// File: common/cu_settings.svh
`ifndef CU_SETTINGS_SVH
`define CU_SETTINGS_SVH

// command FIFO depths, one per job unit
`define CU_VERTEX_FIFO_DEPTH 16
`define CU_EDGE_FIFO_DEPTH   32

// vertex records waiting for the edge unit
`define CU_JOB_QUEUE_DEPTH   8

// alfull rises once fewer entries than this are free
`define CU_ALFULL_MARGIN     4

// vertex reads in flight at once
`define CU_MAX_OUTSTANDING   8

`endif

// File: common/cu_pkg.sv
`default_nettype none

package cu_pkg;

	////////////////////////////////////////
	// job unit identifiers
	////////////////////////////////////////

	typedef enum logic {
		vertex_control_id = 1'b0,
		edge_control_id   = 1'b1
	} cu_id_t;

	////////////////////////////////////////
	// read command line
	////////////////////////////////////////

	typedef struct packed {
		logic        valid;
		cu_id_t      cu_id;
		logic [7:0]  tag;
		logic [63:0] address;
	} cmd_line_t;

	////////////////////////////////////////
	// graph records
	////////////////////////////////////////

	// edge_offset indexes the edge array
	typedef struct packed {
		logic [31:0] degree;
		logic [31:0] edge_offset;
	} vertex_rec_t;

	typedef struct packed {
		logic [31:0] dest;
		logic [31:0] weight;
	} edge_rec_t;

	// one memory word, decoded by the cu_id of its read
	typedef union packed {
		vertex_rec_t vertex_rec;
		edge_rec_t   edge_rec;
	} payload_u;

	// one returning read beat
	typedef struct packed {
		logic       valid;
		cu_id_t     cu_id;
		logic [7:0] tag;
		payload_u   payload;
	} data_line_t;

	// work element descriptor
	typedef struct packed {
		logic        valid;
		logic [63:0] vertex_base;
		logic [63:0] edge_base;
		logic [31:0] num_vertices;
		logic [31:0] num_edges;
	} wed_t;

endpackage

`default_nettype wire

// File: hdl/cmd_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "cu_settings.svh"

module cmd_fifo #(
	parameter int WIDTH = 74,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             valid,
	output logic             empty,
	output logic             full,
	output logic             alfull
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] rd_next;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign rd_next = do_pop ? next_ptr(rd_ptr) : rd_ptr;

	assign empty  = (count == '0);
	assign full   = (int'(count) == DEPTH);
	assign alfull = (DEPTH - int'(count)) < `CU_ALFULL_MARGIN;
	// head register holds a live entry
	assign valid  = !empty;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// registered read of the next head, bypass when it is written now
	always_ff @(posedge clock) begin
		if (do_push && (wr_ptr == rd_next)) begin
			data_out <= data_in;
		end else begin
			data_out <= mem[rd_next];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			rd_ptr <= rd_next;
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/cmd_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_arbiter
	import cu_pkg::*;
#(
	parameter int NUM_REQUESTS = 2
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enabled,
	input  logic [NUM_REQUESTS-1:0]      requests,
	input  cmd_line_t [NUM_REQUESTS-1:0] command_in,
	output logic [NUM_REQUESTS-1:0]      ready,
	output cmd_line_t                    command_out
);

	localparam int PTR_W = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1;

	logic [PTR_W-1:0] rr_ptr;
	logic [PTR_W-1:0] winner;
	logic             grant_any;

	// first request at or after the pointer
	always_comb begin : pick_winner
		int cand;
		winner    = rr_ptr;
		grant_any = 1'b0;
		for (int i = 0; i < NUM_REQUESTS; i++) begin
			cand = int'(rr_ptr) + i;
			if (cand >= NUM_REQUESTS) begin
				cand = cand - NUM_REQUESTS;
			end
			if (!grant_any && requests[cand]) begin
				grant_any = 1'b1;
				winner    = PTR_W'(cand);
			end
		end
	end

	// one pop per grant
	always_comb begin
		ready = '0;
		if (enabled && grant_any) begin
			ready[winner] = 1'b1;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rr_ptr      <= '0;
			command_out <= '0;
		end else if (enabled) begin
			if (grant_any) begin
				command_out <= command_in[winner];
				rr_ptr      <= (winner == PTR_W'(NUM_REQUESTS - 1)) ? '0 : winner + 1'b1;
			end else begin
				command_out <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: cu_control/vertex_job_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "cu_settings.svh"

module vertex_job_unit
	import cu_pkg::*;
(
	input  logic        clock,
	input  logic        rstn,
	input  logic        enabled,
	input  wed_t        wed,
	input  data_line_t  vertex_data,
	input  logic        cmd_alfull,
	output cmd_line_t   command_out,
	input  logic        job_pop,
	output logic        job_valid,
	output vertex_rec_t job,
	output logic [31:0] filtered
);

	// the job queue must absorb every record still in flight
	localparam int ISSUE_LIMIT = (`CU_MAX_OUTSTANDING < `CU_ALFULL_MARGIN) ?
		`CU_MAX_OUTSTANDING : `CU_ALFULL_MARGIN;
	localparam int OUT_W = $clog2(`CU_MAX_OUTSTANDING + 1);

	logic [31:0]      vertex_idx;
	logic [OUT_W-1:0] outstanding;
	logic             issue;
	logic             beat;
	logic             job_push;
	logic             job_alfull;
	vertex_rec_t      record;

	////////////////////////////////////////
	// vertex read issue
	////////////////////////////////////////

	assign issue = enabled && wed.valid && (vertex_idx < wed.num_vertices) &&
		(outstanding < ISSUE_LIMIT) && !cmd_alfull && !job_alfull;

	// vertex records are 8 bytes apart
	always_comb begin
		command_out         = '0;
		command_out.valid   = issue;
		command_out.cu_id   = vertex_control_id;
		command_out.tag     = vertex_idx[7:0];
		command_out.address = wed.vertex_base + {29'd0, vertex_idx, 3'b000};
	end

	////////////////////////////////////////
	// returning vertex records
	////////////////////////////////////////

	assign beat     = enabled && vertex_data.valid && (vertex_data.cu_id == vertex_control_id);
	assign record   = vertex_data.payload.vertex_rec;
	// zero degree vertices never reach the queue
	assign job_push = beat && (record.degree != '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_idx  <= '0;
			outstanding <= '0;
			filtered    <= '0;
		end else if (enabled) begin
			if (!wed.valid) begin
				vertex_idx  <= '0;
				outstanding <= '0;
				filtered    <= '0;
			end else begin
				if (issue) begin
					vertex_idx <= vertex_idx + 1'b1;
				end
				case ({issue, beat})
					2'b10: outstanding <= outstanding + 1'b1;
					2'b01: outstanding <= outstanding - 1'b1;
					default: outstanding <= outstanding;
				endcase
				if (beat && (record.degree == '0)) begin
					filtered <= filtered + 1'b1;
				end
			end
		end
	end

	// vertex job queue
	cmd_fifo #(
		.WIDTH($bits(vertex_rec_t)),
		.DEPTH(`CU_JOB_QUEUE_DEPTH)
	) job_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_push),
		.data_in (record),
		.pop     (job_pop),
		.data_out(job),
		.valid   (job_valid),
		.empty   (),
		.full    (),
		.alfull  (job_alfull)
	);

endmodule

`default_nettype wire

// File: cu_control/edge_job_unit.sv
`timescale 1ns/100ps
`default_nettype none

module edge_job_unit
	import cu_pkg::*;
(
	input  logic        clock,
	input  logic        rstn,
	input  logic        enabled,
	input  wed_t        wed,
	input  data_line_t  edge_data,
	input  logic        cmd_alfull,
	output cmd_line_t   command_out,
	input  logic        job_valid,
	input  vertex_rec_t job,
	output logic        job_pop,
	output logic [31:0] vertices_done,
	output logic [31:0] edges_done,
	output logic [31:0] weight_sum
);

	logic        active;
	vertex_rec_t current;
	logic [31:0] edge_idx;
	logic [7:0]  tag_count;
	logic        issue;
	logic        last_edge;
	logic        beat;
	edge_rec_t   record;

	////////////////////////////////////////
	// vertex job fetch
	////////////////////////////////////////

	// next job only once the current vertex is fully issued
	assign job_pop = enabled && wed.valid && !active && job_valid;

	always_ff @(posedge clock) begin
		if (job_pop) begin
			current <= job;
		end
	end

	////////////////////////////////////////
	// edge read issue
	////////////////////////////////////////

	assign issue     = enabled && wed.valid && active && !cmd_alfull;
	assign last_edge = (edge_idx == current.degree - 1'b1);

	always_comb begin
		command_out         = '0;
		command_out.valid   = issue;
		command_out.cu_id   = edge_control_id;
		command_out.tag     = tag_count;
		command_out.address = wed.edge_base + {29'd0, current.edge_offset + edge_idx, 3'b000};
	end

	// returning edge records
	assign beat   = enabled && edge_data.valid && (edge_data.cu_id == edge_control_id);
	assign record = edge_data.payload.edge_rec;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active        <= 1'b0;
			edge_idx      <= '0;
			tag_count     <= '0;
			vertices_done <= '0;
			edges_done    <= '0;
			weight_sum    <= '0;
		end else if (enabled) begin
			if (!wed.valid) begin
				active        <= 1'b0;
				edge_idx      <= '0;
				tag_count     <= '0;
				vertices_done <= '0;
				edges_done    <= '0;
				weight_sum    <= '0;
			end else begin
				if (job_pop) begin
					active   <= 1'b1;
					edge_idx <= '0;
				end else if (issue) begin
					tag_count <= tag_count + 1'b1;
					if (last_edge) begin
						// vertex counts as done with its last read issued
						active        <= 1'b0;
						vertices_done <= vertices_done + 1'b1;
					end else begin
						edge_idx <= edge_idx + 1'b1;
					end
				end
				if (beat) begin
					edges_done <= edges_done + 1'b1;
					weight_sum <= weight_sum + record.weight;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: cu_control/cu_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "cu_settings.svh"

module cu_control
	import cu_pkg::*;
(
	input  logic        clock,
	input  logic        rstn,
	input  logic        enabled,
	input  wed_t        wed,
	input  data_line_t  read_data_in,
	input  logic        read_buffer_alfull,
	output cmd_line_t   read_command_out,
	output logic [63:0] algorithm_status,
	output logic [31:0] weight_sum
);

	localparam int NUM_REQUESTS = 2;

	wed_t                         wed_latched;
	data_line_t                   read_data_latched;
	data_line_t                   vertex_data;
	data_line_t                   edge_data;
	cmd_line_t                    vertex_command;
	cmd_line_t                    edge_command;
	cmd_line_t                    vertex_fifo_head;
	cmd_line_t                    edge_fifo_head;
	logic                         vertex_fifo_valid;
	logic                         vertex_fifo_empty;
	logic                         vertex_fifo_alfull;
	logic                         edge_fifo_valid;
	logic                         edge_fifo_empty;
	logic                         edge_fifo_alfull;
	logic                         issue_phase;
	logic [NUM_REQUESTS-1:0]      requests;
	logic [NUM_REQUESTS-1:0]      ready;
	cmd_line_t [NUM_REQUESTS-1:0] command_buffer_in;
	cmd_line_t                    arbiter_command;
	logic                         job_pop;
	logic                         job_valid;
	vertex_rec_t                  job;
	logic [31:0]                  filtered;
	logic [31:0]                  vertices_done;
	logic [31:0]                  edges_done;
	logic [31:0]                  unit_weight_sum;
	logic                         done;

	////////////////////////////////////////
	// input latch
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_latched       <= '0;
			read_data_latched <= '0;
		end else if (enabled) begin
			wed_latched       <= wed;
			read_data_latched <= read_data_in;
		end
	end

	////////////////////////////////////////
	// response routing by cu_id
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_data <= '0;
			edge_data   <= '0;
		end else if (enabled) begin
			if (read_data_latched.valid) begin
				case (read_data_latched.cu_id)
					vertex_control_id: begin
						vertex_data <= read_data_latched;
						edge_data   <= '0;
					end
					default: begin
						edge_data   <= read_data_latched;
						vertex_data <= '0;
					end
				endcase
			end else begin
				vertex_data <= '0;
				edge_data   <= '0;
			end
		end
	end

	////////////////////////////////////////
	// job units
	////////////////////////////////////////

	vertex_job_unit vertex_unit (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (enabled),
		.wed        (wed_latched),
		.vertex_data(vertex_data),
		.cmd_alfull (vertex_fifo_alfull),
		.command_out(vertex_command),
		.job_pop    (job_pop),
		.job_valid  (job_valid),
		.job        (job),
		.filtered   (filtered)
	);

	edge_job_unit edge_unit (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.wed          (wed_latched),
		.edge_data    (edge_data),
		.cmd_alfull   (edge_fifo_alfull),
		.command_out  (edge_command),
		.job_valid    (job_valid),
		.job          (job),
		.job_pop      (job_pop),
		.vertices_done(vertices_done),
		.edges_done   (edges_done),
		.weight_sum   (unit_weight_sum)
	);

	////////////////////////////////////////
	// command FIFOs
	////////////////////////////////////////

	cmd_fifo #(
		.WIDTH($bits(cmd_line_t)),
		.DEPTH(`CU_VERTEX_FIFO_DEPTH)
	) vertex_cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (vertex_command.valid),
		.data_in (vertex_command),
		.pop     (ready[0]),
		.data_out(vertex_fifo_head),
		.valid   (vertex_fifo_valid),
		.empty   (vertex_fifo_empty),
		.full    (),
		.alfull  (vertex_fifo_alfull)
	);

	cmd_fifo #(
		.WIDTH($bits(cmd_line_t)),
		.DEPTH(`CU_EDGE_FIFO_DEPTH)
	) edge_cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (edge_command.valid),
		.data_in (edge_command),
		.pop     (ready[1]),
		.data_out(edge_fifo_head),
		.valid   (edge_fifo_valid),
		.empty   (edge_fifo_empty),
		.full    (),
		.alfull  (edge_fifo_alfull)
	);

	////////////////////////////////////////
	// request logic and arbiter
	////////////////////////////////////////

	// requests on every other cycle
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issue_phase <= 1'b0;
		end else if (enabled) begin
			issue_phase <= !issue_phase;
		end
	end

	assign requests[0] = !vertex_fifo_empty && !read_buffer_alfull && issue_phase;
	assign requests[1] = !edge_fifo_empty && !read_buffer_alfull && issue_phase;

	assign command_buffer_in[0] = vertex_fifo_valid ? vertex_fifo_head : '0;
	assign command_buffer_in[1] = edge_fifo_valid ? edge_fifo_head : '0;

	cmd_arbiter #(
		.NUM_REQUESTS(NUM_REQUESTS)
	) read_arbiter (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (enabled),
		.requests   (requests),
		.command_in (command_buffer_in),
		.ready      (ready),
		.command_out(arbiter_command)
	);

	////////////////////////////////////////
	// done compare and output stage
	////////////////////////////////////////

	assign done = wed_latched.valid &&
		(wed_latched.num_vertices == filtered + vertices_done) &&
		(wed_latched.num_edges == edges_done);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_out <= '0;
			algorithm_status <= '0;
			weight_sum       <= '0;
		end else if (enabled) begin
			read_command_out <= arbiter_command;
			algorithm_status <= done ? {edges_done, filtered + vertices_done} : '0;
			weight_sum       <= unit_weight_sum;
		end
	end

endmodule

`default_nettype wire

// File: tb/cu_control_chk.sv
`timescale 1ns/100ps
`default_nettype none

module cu_control_chk
	import cu_pkg::*;
(
	input logic        clock,
	input logic        rstn,
	input logic        enabled,
	input logic        read_buffer_alfull,
	input cmd_line_t   read_command_out,
	input logic [1:0]  ready,
	input cmd_line_t   arbiter_command,
	input logic        job_pop,
	input vertex_rec_t job
);

	int failures = 0;

	// output idle from the second enabled edge after alfull
	alfull_stops_commands: assert property (@(posedge clock) disable iff (!rstn)
		$past(read_buffer_alfull, 2) && $past(enabled) && $past(enabled, 2)
		|-> !read_command_out.valid)
	else begin
		failures++;
		$error("read command left while read_buffer_alfull was high");
	end

	// a popped FIFO head is a live command
	pop_gives_command: assert property (@(posedge clock) disable iff (!rstn)
		(ready != 2'b00) |=> arbiter_command.valid)
	else begin
		failures++;
		$error("arbiter popped a command FIFO but registered no valid command");
	end

	// job queue hands out only vertices that have edges
	job_has_edges: assert property (@(posedge clock) disable iff (!rstn)
		job_pop |-> (job.degree != '0))
	else begin
		failures++;
		$error("edge unit popped a vertex job with zero degree");
	end

endmodule

`default_nettype wire

// File: tb/cu_control_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cu_control_tb
	import cu_pkg::*;
();

	localparam int          NUM_ROWS     = 4;
	localparam int          MAX_VERTICES = 64;
	localparam int          MAX_EDGES    = 512;
	localparam logic [63:0] VERTEX_BASE  = 64'h0000_0000_1000_0000;
	localparam logic [63:0] EDGE_BASE    = 64'h0000_0000_4000_0000;

	// vertices, max degree, percent zero degree, back-pressure
	int run_table [NUM_ROWS][4] = '{
		'{12, 4, 0, 0},
		'{40, 6, 50, 0},
		'{32, 8, 90, 1},
		'{48, 5, 20, 1}
	};

	logic        clock;
	logic        rstn;
	logic        enabled;
	wed_t        wed;
	data_line_t  read_data_in;
	logic        read_buffer_alfull;
	cmd_line_t   read_command_out;
	logic [63:0] algorithm_status;
	logic [31:0] weight_sum;

	// host memory image and read bookkeeping
	logic [63:0] vertex_mem [MAX_VERTICES];
	logic [63:0] edge_mem [MAX_EDGES];
	int          vertex_hits [MAX_VERTICES];
	int          edge_hits [MAX_EDGES];
	int          num_vertices;
	int          num_edges;
	int          expected_filtered;
	logic [31:0] expected_sum;
	logic [31:0] image_rng = 32'h1d69_4743;
	logic [31:0] model_rng = 32'h1d69_4743;
	cmd_line_t   pending_cmd [$];
	int          pending_due [$];
	cmd_line_t   last_cmd = '0;
	logic        enabled_seen = 1'b0;
	int          cycle = 0;
	int          timeout_limit = 0;
	int          pause_left = 0;
	int          bp_left = 0;
	logic        bp_on = 1'b0;
	int          errors = 0;

	cu_control dut (.*);

	bind cu_control cu_control_chk chk (.*);

	always #2 clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		errors++;
		$display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
	endtask

	////////////////////////////////////////
	// graph image for one run
	////////////////////////////////////////

	task automatic build_image(input int row);
		int        degree;
		edge_rec_t rec;
		num_vertices      = run_table[row][0];
		num_edges         = 0;
		expected_filtered = 0;
		expected_sum      = '0;
		for (int i = 0; i < num_vertices; i++) begin
			image_rng = xorshift(image_rng);
			if (int'(image_rng % 100) < run_table[row][2]) begin
				degree = 0;
				expected_filtered++;
			end else begin
				degree = 1 + int'(image_rng[23:8]) % run_table[row][1];
			end
			// degree in the upper word and edge offset in the lower
			vertex_mem[i]  = {32'(degree), 32'(num_edges)};
			vertex_hits[i] = 0;
			for (int j = 0; j < degree; j++) begin
				image_rng  = xorshift(image_rng);
				rec.dest   = 32'(image_rng[15:0]) % 32'(num_vertices);
				rec.weight = {16'd0, image_rng[31:16]};
				edge_mem[num_edges]  = rec;
				edge_hits[num_edges] = 0;
				expected_sum += rec.weight;
				num_edges++;
			end
		end
	endtask

	// returns the word at a read address and counts the read
	function automatic logic [63:0] answer_read(input cmd_line_t cmd);
		logic [63:0] offset;
		if (cmd.cu_id == vertex_control_id) begin
			offset = cmd.address - VERTEX_BASE;
			if (cmd.address >= VERTEX_BASE && offset < 64'(num_vertices) * 8 &&
					offset[2:0] == 3'd0) begin
				vertex_hits[offset[31:3]]++;
				return vertex_mem[offset[31:3]];
			end
		end else begin
			offset = cmd.address - EDGE_BASE;
			if (cmd.address >= EDGE_BASE && offset < 64'(num_edges) * 8 &&
					offset[2:0] == 3'd0) begin
				edge_hits[offset[31:3]]++;
				return edge_mem[offset[31:3]];
			end
		end
		errors++;
		$display("read of address 0x%h by unit %0d is outside the graph arrays",
			cmd.address, cmd.cu_id);
		return '0;
	endfunction

	////////////////////////////////////////
	// host memory model
	////////////////////////////////////////

	// commands taken only on edges where the DUT was enabled
	always @(negedge clock) begin
		if (enabled_seen && read_command_out.valid) begin
			model_rng = xorshift(model_rng);
			pending_cmd.push_back(read_command_out);
			pending_due.push_back(cycle + 1 + int'(model_rng % 4));
		end
		if (!enabled_seen && read_command_out !== last_cmd) begin
			errors++;
			$display("read_command_out changed at cycle %0d while enabled was low", cycle);
		end
		last_cmd     = read_command_out;
		enabled_seen = enabled;
	end

	always @(posedge clock) begin : drive
		logic       en_next;
		cmd_line_t  cmd;
		data_line_t beat;
		cycle   <= cycle + 1;
		en_next = (pause_left == 0);
		enabled <= en_next;
		if (pause_left > 0) begin
			pause_left <= pause_left - 1;
		end
		// alfull windows of 3 to 10 cycles
		model_rng = xorshift(model_rng);
		if (bp_left > 0) begin
			bp_left <= bp_left - 1;
		end else if (bp_on && model_rng[3:0] == 4'd0) begin
			bp_left <= 3 + int'(model_rng[6:4]);
		end
		read_buffer_alfull <= (bp_left > 0);
		beat = '0;
		if (en_next && pending_cmd.size() > 0 && cycle >= pending_due[0]) begin
			cmd = pending_cmd.pop_front();
			void'(pending_due.pop_front());
			beat.valid   = 1'b1;
			beat.cu_id   = cmd.cu_id;
			beat.tag     = cmd.tag;
			beat.payload = answer_read(cmd);
		end
		read_data_in <= beat;
	end

	always @(posedge clock) begin
		if (cycle >= timeout_limit) begin
			$display("run timed out after %0d cycles without completing", cycle);
			$display("%0d errors, %0d assertion failures", errors, dut.chk.failures);
			$display("Result: FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// runs
	////////////////////////////////////////

	task automatic run_graph(input int row);
		build_image(row);
		timeout_limit += 40 * num_vertices + 8 * num_edges;
		@(posedge clock);
		bp_on <= (run_table[row][3] != 0);
		wed   <= '{valid: 1'b1, vertex_base: VERTEX_BASE, edge_base: EDGE_BASE,
			num_vertices: 32'(num_vertices), num_edges: 32'(num_edges)};
		// freeze the block partway through
		repeat (30) @(posedge clock);
		pause_left <= 20;
		@(negedge clock);
		while (algorithm_status == '0) @(negedge clock);
		if (algorithm_status !== {32'(num_edges), 32'(num_vertices)})
			report_mismatch("algorithm_status", algorithm_status,
				{32'(num_edges), 32'(num_vertices)});
		if (weight_sum !== expected_sum)
			report_mismatch("weight_sum", weight_sum, expected_sum);
		if (dut.filtered !== 32'(expected_filtered))
			report_mismatch("filtered", dut.filtered, expected_filtered);
		for (int i = 0; i < num_vertices; i++) begin
			if (vertex_hits[i] != 1) begin
				errors++;
				$display("vertex record %0d was read %0d times", i, vertex_hits[i]);
			end
		end
		for (int i = 0; i < num_edges; i++) begin
			if (edge_hits[i] != 1) begin
				errors++;
				$display("edge record %0d was read %0d times", i, edge_hits[i]);
			end
		end
		@(posedge clock);
		bp_on <= 1'b0;
		wed   <= '0;
		while (algorithm_status != '0) @(negedge clock);
	endtask

	initial begin : main
		clock              = 1'b0;
		rstn               = 1'b0;
		enabled            = 1'b1;
		wed                = '0;
		read_data_in       = '0;
		read_buffer_alfull = 1'b0;
		timeout_limit      = 200;
		repeat (2) @(posedge clock);
		rstn <= 1'b1;
		repeat (3) @(negedge clock);
		// idle outputs before any work element
		if (read_command_out.valid !== 1'b0)
			report_mismatch("read_command_out.valid", read_command_out.valid, 0);
		if (algorithm_status !== '0)
			report_mismatch("algorithm_status", algorithm_status, 0);
		if (weight_sum !== '0)
			report_mismatch("weight_sum", weight_sum, 0);
		for (int r = 0; r < NUM_ROWS; r++) begin
			run_graph(r);
		end
		$display("%0d errors, %0d assertion failures", errors, dut.chk.failures);
		if (errors == 0 && dut.chk.failures == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+common
common/cu_pkg.sv
hdl/cmd_fifo.sv
hdl/cmd_arbiter.sv
cu_control/vertex_job_unit.sv
cu_control/edge_job_unit.sv
cu_control/cu_control.sv
tb/cu_control_chk.sv
tb/cu_control_tb.sv

// File: Bender.yml
package:
  name: cu_control

export_include_dirs:
  - common

sources:
  - common/cu_pkg.sv
  - hdl/cmd_fifo.sv
  - hdl/cmd_arbiter.sv
  - cu_control/vertex_job_unit.sv
  - cu_control/edge_job_unit.sv
  - cu_control/cu_control.sv
  - target: simulation
    files:
      - tb/cu_control_chk.sv
      - tb/cu_control_tb.sv
